// ==== files.f ====
hw/block_render_pkg.sv
hw/board_store.sv
hw/face_scanner.sv
hw/entry_fifo.sv
hw/cube_corner_gen.sv
hw/block_render_top.sv
sim/block_render_assert.sv
sim/block_render_tb.sv

// ==== sim/block_render_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_render_tb
    import block_render_pkg::*;
();

    localparam int cell_pitch   = 24;
    localparam int origin_x     = 200;
    localparam int origin_y     = 100;
    localparam int block_depth  = 24;
    localparam int fifo_depth   = 4;
    localparam int clk_period   = 20;
    localparam int num_tests    = 5;
    localparam int max_vertices = 8 * 40;
    localparam int test_cycles  = board_cells + 2 * max_vertices + 1000;

    logic                  sysclk;
    logic                  reset;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [cell_adr_w-1:0] wb_adr;
    logic [7:0]            wb_dat_w;
    logic                  scan_start;
    logic                  vtx_ready;
    logic [7:0]            wb_dat_r;
    logic                  wb_ack;
    logic                  scan_busy;
    logic                  scan_done;
    logic                  vtx_valid;
    logic [coord_w-1:0]    vtx_x;
    logic [coord_w-1:0]    vtx_y;
    logic [depth_w-1:0]    vtx_z;
    cell_color_t           vtx_color;
    face_mask_t            vtx_faces;
    logic                  vtx_last;

    // reference board and expected vertex stream
    cell_color_t board_model [board_cells];
    vertex_t     exp_q [$];
    integer      seed;

    block_render_top #(
        .cell_pitch  (cell_pitch),
        .origin_x    (origin_x),
        .origin_y    (origin_y),
        .block_depth (block_depth),
        .fifo_depth  (fifo_depth)
    ) UUT (
        .sysclk     (sysclk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .scan_start (scan_start),
        .vtx_ready  (vtx_ready),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .scan_busy  (scan_busy),
        .scan_done  (scan_done),
        .vtx_valid  (vtx_valid),
        .vtx_x      (vtx_x),
        .vtx_y      (vtx_y),
        .vtx_z      (vtx_z),
        .vtx_color  (vtx_color),
        .vtx_faces  (vtx_faces),
        .vtx_last   (vtx_last)
    );

    initial begin
        sysclk = 1'b0;
        forever #(clk_period / 2) sysclk = ~sysclk;
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(negedge sysclk);
        reset = 1'b0;
        foreach (board_model[i]) begin
            board_model[i] = '0;
        end
    endtask

    ////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////

    task automatic wb_access(input bit we, input int adr, input int data,
                             output logic [7:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = cell_adr_w'(adr);
        wb_dat_w = 8'(data);
        n = 0;
        @(negedge sysclk);
        while (!wb_ack) begin
            n++;
            assert (n < 10) else fail_run("wishbone access was not acknowledged");
            @(negedge sysclk);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge sysclk);
    endtask

    task automatic wb_write(input int adr, input int data);
        logic [7:0] unused;
        wb_access(1'b1, adr, data, unused);
        if (adr < board_cells) begin
            board_model[adr] = cell_color_t'(data);
        end
    endtask

    task automatic wb_read(input int adr, output logic [7:0] data);
        wb_access(1'b0, adr, 0, data);
    endtask

    task automatic check_read(input int adr);
        logic [7:0] data;
        wb_read(adr, data);
        check_eq("wb_dat_r", data, (adr < board_cells) ? board_model[adr] : 0);
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic cell_color_t cell_at(input int r, input int c);
        if (r < 0 || r >= board_rows || c < 0 || c >= board_cols) begin
            return '0;
        end
        return board_model[r * board_cols + c];
    endfunction

    task automatic build_expected();
        vertex_t    v;
        face_mask_t f;
        exp_q.delete();
        for (int r = 0; r < board_rows; r++) begin
            for (int c = 0; c < board_cols; c++) begin
                if (cell_at(r, c) != '0) begin
                    // outside the board counts as empty
                    f.up    = (cell_at(r - 1, c) == '0);
                    f.down  = (cell_at(r + 1, c) == '0);
                    f.left  = (cell_at(r, c - 1) == '0);
                    f.right = (cell_at(r, c + 1) == '0);
                    for (int k = 0; k < 8; k++) begin
                        v.x = coord_w'(origin_x + c * cell_pitch + ((k & 1) ? cell_pitch : 0));
                        v.y = coord_w'(origin_y + r * cell_pitch + ((k & 2) ? cell_pitch : 0));
                        v.z     = (k & 4) ? depth_w'(block_depth) : '0;
                        v.color = cell_at(r, c);
                        v.faces = f;
                        v.last  = (k == 7);
                        exp_q.push_back(v);
                    end
                end
            end
        end
    endtask

    // start a scan and compare every vertex as it leaves the DUT
    task automatic run_scan(input bit random_ready, input bit restart);
        int      got;
        int      cycles;
        int      limit;
        bit      done_seen;
        vertex_t e;
        build_expected();
        got       = 0;
        cycles    = 0;
        done_seen = 1'b0;
        limit     = 4 * (board_cells + exp_q.size()) + 100;
        scan_start = 1'b1;
        @(negedge sysclk);
        scan_start = 1'b0;
        check_eq("scan_busy", scan_busy, 1);
        while (!(done_seen && got == exp_q.size())) begin
            cycles++;
            assert (cycles < limit) else fail_run("scan or vertex stream did not finish in time");
            vtx_ready  = random_ready ? (($random(seed) % 2) != 0) : 1'b1;
            scan_start = restart && (cycles == 150);
            if (scan_start) begin
                assert (scan_busy) else fail_run("scan ended before the repeated start");
            end
            if (vtx_valid && vtx_ready) begin
                assert (got < exp_q.size()) else fail_run("more vertices than expected");
                e = exp_q[got];
                check_eq("vtx_x", vtx_x, e.x);
                check_eq("vtx_y", vtx_y, e.y);
                check_eq("vtx_z", vtx_z, e.z);
                check_eq("vtx_color", vtx_color, e.color);
                check_eq("vtx_faces", vtx_faces, e.faces);
                check_eq("vtx_last", vtx_last, e.last);
                got++;
            end
            if (scan_done) begin
                done_seen = 1'b1;
            end
            @(negedge sysclk);
        end
        scan_start = 1'b0;
        vtx_ready  = 1'b1;
        repeat (30) begin
            assert (!vtx_valid) else fail_run("extra vertex after the expected sequence");
            assert (!scan_busy) else fail_run("a second scan started during a busy scan");
            @(negedge sysclk);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_after_reset();
        apply_reset();
        check_eq("wb_ack", wb_ack, 0);
        check_eq("scan_busy", scan_busy, 0);
        check_eq("scan_done", scan_done, 0);
        check_eq("vtx_valid", vtx_valid, 0);
        wb_write(0, 1);
        wb_write(57, 6);
        wb_write(120, 8'hfd);
        wb_write(199, 7);
        // indices past the board are acked and ignored
        wb_write(200, 3);
        wb_write(255, 4);
        check_read(0);
        check_read(57);
        check_read(120);
        check_read(199);
        check_read(200);
        check_read(255);
    endtask

    task automatic test_single_block();
        apply_reset();
        wb_write(104, 3);
        run_scan(1'b0, 1'b0);
    endtask

    task automatic test_exposure();
        apply_reset();
        wb_write(0, 1);
        wb_write(9, 2);
        wb_write(190, 4);
        wb_write(199, 5);
        // row of three with one cell hanging below its end
        wb_write(53, 6);
        wb_write(54, 7);
        wb_write(55, 1);
        wb_write(65, 2);
        run_scan(1'b0, 1'b0);
    endtask

    task automatic test_empty_and_restart();
        apply_reset();
        run_scan(1'b0, 1'b1);
        wb_write(87, 2);
        run_scan(1'b0, 1'b1);
    endtask

    task automatic test_back_pressure();
        apply_reset();
        repeat (30) begin
            wb_write({$random(seed)} % board_cells, ({$random(seed)} % 7) + 1);
        end
        run_scan(1'b1, 1'b0);
    endtask

    initial begin
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        scan_start = 1'b0;
        vtx_ready  = 1'b0;
        seed       = 32'h3724;
        test_after_reset();
        test_single_block();
        test_exposure();
        test_empty_and_restart();
        test_back_pressure();
        if (UUT.u_assert.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("bound handshake assertions reported failures");
        end
    end

    // budget per test covers a full scan plus the vertex stream
    initial begin
        #(num_tests * test_cycles * clk_period);
        fail_run("watchdog timeout, the tests did not finish");
    end

endmodule

`default_nettype wire

// ==== sim/block_render_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_render_assert
    import block_render_pkg::*;
(
    input wire logic               sysclk,
    input wire logic               reset,
    input wire logic               wb_ack,
    input wire logic               scan_busy,
    input wire logic               scan_done,
    input wire logic               vtx_valid,
    input wire logic               vtx_ready,
    input wire logic [coord_w-1:0] vtx_x,
    input wire logic [coord_w-1:0] vtx_y,
    input wire logic [depth_w-1:0] vtx_z,
    input wire cell_color_t        vtx_color,
    input wire face_mask_t         vtx_faces,
    input wire logic               vtx_last
);

    int fail_count = 0;

    // a stalled vertex holds until it is taken
    vtx_hold: assert property (@(posedge sysclk) disable iff (reset)
        (vtx_valid && !vtx_ready) |=> (vtx_valid && $stable(vtx_x) && $stable(vtx_y)
            && $stable(vtx_z) && $stable(vtx_color) && $stable(vtx_faces)
            && $stable(vtx_last)))
    else begin
        $error("vertex stream changed while stalled");
        fail_count++;
    end

    ack_single: assert property (@(posedge sysclk) disable iff (reset)
        wb_ack |=> !wb_ack)
    else begin
        $error("wishbone ack held for two cycles");
        fail_count++;
    end

    done_idle: assert property (@(posedge sysclk) disable iff (reset)
        scan_done |-> !scan_busy)
    else begin
        $error("scan done raised while still busy");
        fail_count++;
    end

endmodule

bind block_render_top block_render_assert u_assert (
    .sysclk    (sysclk),
    .reset     (reset),
    .wb_ack    (wb_ack),
    .scan_busy (scan_busy),
    .scan_done (scan_done),
    .vtx_valid (vtx_valid),
    .vtx_ready (vtx_ready),
    .vtx_x     (vtx_x),
    .vtx_y     (vtx_y),
    .vtx_z     (vtx_z),
    .vtx_color (vtx_color),
    .vtx_faces (vtx_faces),
    .vtx_last  (vtx_last)
);

`default_nettype wire

// ==== hw/block_render_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_render_top
    import block_render_pkg::*;
#(
    parameter int cell_pitch  = 24,
    parameter int origin_x    = 200,
    parameter int origin_y    = 100,
    parameter int block_depth = 24,
    parameter int fifo_depth  = 4
) (
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  wire logic                  wb_cyc,
    input  wire logic                  wb_stb,
    input  wire logic                  wb_we,
    input  wire logic [cell_adr_w-1:0] wb_adr,
    input  wire logic [7:0]            wb_dat_w,
    input  wire logic                  scan_start,
    input  wire logic                  vtx_ready,
    output logic [7:0]                 wb_dat_r,
    output logic                       wb_ack,
    output logic                       scan_busy,
    output logic                       scan_done,
    output logic                       vtx_valid,
    output logic [coord_w-1:0]         vtx_x,
    output logic [coord_w-1:0]         vtx_y,
    output logic [depth_w-1:0]         vtx_z,
    output cell_color_t                vtx_color,
    output face_mask_t                 vtx_faces,
    output logic                       vtx_last
);

    logic [board_cells-1:0] occupied;
    logic [cell_adr_w-1:0]  scan_index;
    cell_color_t            scan_color;

    // scanner to entry fifo
    logic                   scan_valid;
    logic                   scan_ready;
    face_entry_t            scan_entry;

    // entry fifo to corner generator
    logic                   ent_valid;
    logic                   ent_ready;
    face_entry_t            ent_data;

    // corner generator to vertex fifo
    logic                   gen_valid;
    logic                   gen_ready;
    vertex_t                gen_vtx;
    vertex_t                vtx_q;

    ////////////////////////////////////////
    // board and scan
    ////////////////////////////////////////

    board_store u_board_store (
        .sysclk     (sysclk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .scan_index (scan_index),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .occupied   (occupied),
        .scan_color (scan_color)
    );

    face_scanner #(
        .cell_pitch (cell_pitch),
        .origin_x   (origin_x),
        .origin_y   (origin_y)
    ) u_face_scanner (
        .sysclk      (sysclk),
        .reset       (reset),
        .scan_start  (scan_start),
        .occupied    (occupied),
        .scan_color  (scan_color),
        .in_ready    (scan_ready),
        .scan_index  (scan_index),
        .scan_busy   (scan_busy),
        .scan_done   (scan_done),
        .entry_valid (scan_valid),
        .entry       (scan_entry)
    );

    ////////////////////////////////////////
    // entry stream to vertex stream
    ////////////////////////////////////////

    entry_fifo #(
        .payload_t  (face_entry_t),
        .fifo_depth (fifo_depth)
    ) u_entry_fifo (
        .sysclk    (sysclk),
        .reset     (reset),
        .in_valid  (scan_valid),
        .in_data   (scan_entry),
        .out_ready (ent_ready),
        .in_ready  (scan_ready),
        .out_valid (ent_valid),
        .out_data  (ent_data)
    );

    cube_corner_gen #(
        .cell_pitch  (cell_pitch),
        .block_depth (block_depth)
    ) u_cube_corner_gen (
        .sysclk        (sysclk),
        .reset         (reset),
        .entry_valid   (ent_valid),
        .entry         (ent_data),
        .vtx_out_ready (gen_ready),
        .entry_ready   (ent_ready),
        .vtx_out_valid (gen_valid),
        .vtx_out       (gen_vtx)
    );

    entry_fifo #(
        .payload_t  (vertex_t),
        .fifo_depth (fifo_depth)
    ) u_vertex_fifo (
        .sysclk    (sysclk),
        .reset     (reset),
        .in_valid  (gen_valid),
        .in_data   (gen_vtx),
        .out_ready (vtx_ready),
        .in_ready  (gen_ready),
        .out_valid (vtx_valid),
        .out_data  (vtx_q)
    );

    // vertex fields out as loose ports
    assign vtx_x     = vtx_q.x;
    assign vtx_y     = vtx_q.y;
    assign vtx_z     = vtx_q.z;
    assign vtx_color = vtx_q.color;
    assign vtx_faces = vtx_q.faces;
    assign vtx_last  = vtx_q.last;

endmodule

`default_nettype wire

// ==== hw/cube_corner_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module cube_corner_gen
    import block_render_pkg::*;
#(
    parameter int cell_pitch  = 24,
    parameter int block_depth = 24
) (
    input  wire logic        sysclk,
    input  wire logic        reset,
    input  wire logic        entry_valid,
    input  wire face_entry_t entry,
    input  wire logic        vtx_out_ready,
    output logic             entry_ready,
    output logic             vtx_out_valid,
    output vertex_t          vtx_out
);

    face_entry_t held;
    logic        loaded;
    logic [2:0]  corner;
    logic        vtx_fire;
    logic        last_corner;

    assign last_corner   = (corner == 3'd7);
    assign vtx_fire      = loaded && vtx_out_ready;
    assign vtx_out_valid = loaded;

    // next entry may enter as corner 7 leaves
    assign entry_ready = !loaded || (vtx_fire && last_corner);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            loaded <= 1'b0;
            corner <= '0;
        end else if (entry_valid && entry_ready) begin
            loaded <= 1'b1;
            corner <= '0;
        end else if (vtx_fire) begin
            corner <= corner + 1'b1;
            if (last_corner) begin
                loaded <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (entry_valid && entry_ready) begin
            held <= entry;
        end
    end

    ////////////////////////////////////////
    // corner k from its index bits
    ////////////////////////////////////////

    always_comb begin
        vtx_out.x     = held.x + (corner[0] ? coord_w'(cell_pitch) : '0);
        vtx_out.y     = held.y + (corner[1] ? coord_w'(cell_pitch) : '0);
        // bit 2 selects the far face
        vtx_out.z     = corner[2] ? depth_w'(block_depth) : '0;
        vtx_out.color = held.color;
        vtx_out.faces = held.faces;
        vtx_out.last  = last_corner;
    end

endmodule

`default_nettype wire

// ==== hw/entry_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module entry_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  fifo_depth = 4
) (
    input  wire logic     sysclk,
    input  wire logic     reset,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    input  wire logic     out_ready,
    output logic          in_ready,
    output logic          out_valid,
    output payload_t      out_data
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    payload_t         mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // pointer advance with wrap for any depth
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/face_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module face_scanner
    import block_render_pkg::*;
#(
    parameter int cell_pitch = 24,
    parameter int origin_x   = 200,
    parameter int origin_y   = 100
) (
    input  wire logic                   sysclk,
    input  wire logic                   reset,
    input  wire logic                   scan_start,
    input  wire logic [board_cells-1:0] occupied,
    input  wire cell_color_t            scan_color,
    input  wire logic                   in_ready,
    output logic [cell_adr_w-1:0]       scan_index,
    output logic                        scan_busy,
    output logic                        scan_done,
    output logic                        entry_valid,
    output face_entry_t                 entry
);

    localparam int row_w = $clog2(board_rows);
    localparam int col_w = $clog2(board_cols);

    logic [row_w-1:0]      row;
    logic [col_w-1:0]      col;
    logic [coord_w-1:0]    pos_x;
    logic [coord_w-1:0]    pos_y;
    logic                  here;
    logic                  last_cell;
    logic                  step;
    logic                  at_top;
    logic                  at_bottom;
    logic                  at_left;
    logic                  at_right;
    logic [cell_adr_w-1:0] up_idx;
    logic [cell_adr_w-1:0] down_idx;
    logic [cell_adr_w-1:0] left_idx;
    logic [cell_adr_w-1:0] right_idx;
    face_mask_t            faces;

    assign here      = occupied[scan_index];
    assign last_cell = (scan_index == cell_adr_w'(board_cells - 1));

    // empty cells never wait on the fifo
    assign step = scan_busy && (!here || in_ready);

    ////////////////////////////////////////
    // neighbour lookup
    ////////////////////////////////////////

    assign at_top    = (row == '0);
    assign at_bottom = (row == row_w'(board_rows - 1));
    assign at_left   = (col == '0);
    assign at_right  = (col == col_w'(board_cols - 1));

    // clamp to the cell itself at the edges, edge flag wins anyway
    assign up_idx    = at_top    ? scan_index : scan_index - cell_adr_w'(board_cols);
    assign down_idx  = at_bottom ? scan_index : scan_index + cell_adr_w'(board_cols);
    assign left_idx  = at_left   ? scan_index : scan_index - 1'b1;
    assign right_idx = at_right  ? scan_index : scan_index + 1'b1;

    always_comb begin
        faces.up    = at_top    || !occupied[up_idx];
        faces.down  = at_bottom || !occupied[down_idx];
        faces.left  = at_left   || !occupied[left_idx];
        faces.right = at_right  || !occupied[right_idx];
    end

    assign entry_valid = scan_busy && here;

    always_comb begin
        entry.faces = faces;
        entry.color = scan_color;
        entry.x     = pos_x;
        entry.y     = pos_y;
    end

    ////////////////////////////////////////
    // row-major walk
    ////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (reset) begin
            scan_busy  <= 1'b0;
            scan_done  <= 1'b0;
            scan_index <= '0;
            row        <= '0;
            col        <= '0;
        end else begin
            scan_done <= 1'b0;
            if (!scan_busy) begin
                if (scan_start) begin
                    scan_busy  <= 1'b1;
                    scan_index <= '0;
                    row        <= '0;
                    col        <= '0;
                end
            end else if (step) begin
                if (last_cell) begin
                    scan_busy <= 1'b0;
                    scan_done <= 1'b1;
                end else begin
                    scan_index <= scan_index + 1'b1;
                    if (at_right) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    // screen origin follows the counters by adding the pitch
    always_ff @(posedge sysclk) begin
        if (!scan_busy) begin
            pos_x <= coord_w'(origin_x);
            pos_y <= coord_w'(origin_y);
        end else if (step && !last_cell) begin
            if (at_right) begin
                pos_x <= coord_w'(origin_x);
                pos_y <= pos_y + coord_w'(cell_pitch);
            end else begin
                pos_x <= pos_x + coord_w'(cell_pitch);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/board_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_store
    import block_render_pkg::*;
(
    input  wire logic                  sysclk,
    input  wire logic                  reset,
    input  wire logic                  wb_cyc,
    input  wire logic                  wb_stb,
    input  wire logic                  wb_we,
    input  wire logic [cell_adr_w-1:0] wb_adr,
    input  wire logic [7:0]            wb_dat_w,
    input  wire logic [cell_adr_w-1:0] scan_index,
    output logic [7:0]                 wb_dat_r,
    output logic                       wb_ack,
    output logic [board_cells-1:0]     occupied,
    output cell_color_t                scan_color
);

    cell_color_t cells [board_cells];
    logic        wb_req;
    logic        adr_ok;

    // new request only while no ack is pending
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // indices past the board are acked but do nothing
    assign adr_ok = (wb_adr < cell_adr_w'(board_cells));

    ////////////////////////////////////////
    // wishbone side
    ////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            for (int i = 0; i < board_cells; i++) begin
                cells[i] <= '0;
            end
        end else begin
            wb_ack <= wb_req;
            // write lands on the same edge that raises ack
            if (wb_req && wb_we && adr_ok) begin
                cells[wb_adr] <= cell_color_t'(wb_dat_w[2:0]);
            end
        end
    end

    // read data, valid during the ack cycle
    always_ff @(posedge sysclk) begin
        if (wb_req) begin
            wb_dat_r <= adr_ok ? {5'b0, cells[wb_adr]} : 8'h00;
        end
    end

    ////////////////////////////////////////
    // scanner side
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < board_cells; i++) begin
            occupied[i] = |cells[i];
        end
    end

    assign scan_color = (scan_index < cell_adr_w'(board_cells)) ? cells[scan_index] : '0;

endmodule

`default_nettype wire

// ==== hw/block_render_pkg.sv ====
`default_nettype none

package block_render_pkg;

    ////////////////////////////////////////
    // board geometry
    ////////////////////////////////////////

    localparam int board_cols  = 10;
    localparam int board_rows  = 20;
    localparam int board_cells = board_cols * board_rows;

    // cell index, also the wishbone address
    localparam int cell_adr_w = 8;

    // screen coordinate and corner depth widths
    localparam int coord_w = 11;
    localparam int depth_w = 6;

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // zero means an empty cell
    typedef logic [2:0] cell_color_t;

    // set bit = that side is exposed
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } face_mask_t;

    // one build list entry, 29 bits
    typedef struct packed {
        face_mask_t           faces;
        cell_color_t          color;
        logic [coord_w-1:0]   x;
        logic [coord_w-1:0]   y;
    } face_entry_t;

    // one cube corner, 36 bits
    typedef struct packed {
        logic [coord_w-1:0]   x;
        logic [coord_w-1:0]   y;
        logic [depth_w-1:0]   z;
        cell_color_t          color;
        face_mask_t           faces;
        logic                 last;
    } vertex_t;

endpackage

`default_nettype wire
